//--- hw/command_decoder.sv
`default_nettype none

module command_decoder import stepper_pkg::*; #(
  parameter int divisor_init = divisor_reset
) (
  input  logic                             CLK,
  input  logic                             reset,
  input  logic [word_width-1:0]            word_data,
  input  logic                             word_valid,
  input  logic                             move_busy,
  output logic                             move_start,
  output logic                             move_dir,
  output logic [duration_width-1:0]        move_duration,
  output logic signed [rate_width-1:0]     move_rate,
  output logic signed [rate_width-1:0]     move_accel,
  output logic [divisor_width-1:0]         tick_divisor,
  output logic [ms_width-1:0]              microstep_code,
  output logic [7:0]                       dropped_moves
);

  typedef enum logic {st_header, st_data} state_t;

  state_t                   state;
  logic [1:0]               word_count;    // Data word within a move message
  logic [hdr_width-1:0]     header;
  logic [divisor_width-1:0] div_field;
  logic [2:0]               ms_field;
  logic                     last_word;

  assign header    = word_data[word_width-1 -: hdr_width];
  assign div_field = word_data[divisor_width-1:0];
  assign ms_field  = word_data[2:0];
  assign last_word = (state == st_data) && (word_count == 2'd2);

  always_ff @(posedge CLK) begin
    if (reset) begin
      state          <= st_header;
      word_count     <= '0;
      move_start     <= 1'b0;
      tick_divisor   <= divisor_width'(divisor_init);
      microstep_code <= '0;
      dropped_moves  <= '0;
    end else begin
      move_start <= 1'b0;
      if (word_valid) begin
        case (state)
          st_header: begin
            case (header)
              hdr_move: begin
                state      <= st_data;
                word_count <= '0;
              end
              hdr_divisor: begin
                // Zero would stall the tick divider
                tick_divisor <= (div_field == '0) ? divisor_width'(1) : div_field;
              end
              hdr_microstep: begin
                if (ms_field > 3'(ms_max)) microstep_code <= ms_width'(ms_max);
                else microstep_code <= ms_field[ms_width-1:0];
              end
              default: ;                   // Unknown header, stay put
            endcase
          end
          st_data: begin
            word_count <= word_count + 1'b1;
            if (last_word) begin
              state <= st_header;
              // No move queue, a busy profile loses the new move
              if (move_busy) dropped_moves <= dropped_moves + 1'b1;
              else move_start <= 1'b1;
            end
          end
          default: state <= st_header;
        endcase
      end
    end
  end

  // Move fields, only sampled by the profile on move_start
  always_ff @(posedge CLK) begin
    if (word_valid) begin
      if (state == st_header && header == hdr_move) begin
        move_dir <= word_data[0];
      end
      if (state == st_data) begin
        case (word_count)
          2'd0: move_duration <= word_data[duration_width-1:0];
          2'd1: move_rate <= word_data[rate_width-1:0];
          default: move_accel <= word_data[rate_width-1:0];
        endcase
      end
    end
  end

endmodule

`default_nettype wire

//--- hw/dual_hbridge.sv
`default_nettype none

module dual_hbridge import stepper_pkg::*; (
  input  logic                CLK,
  input  logic                reset,
  input  logic                step,
  input  logic                dir,
  input  logic [ms_width-1:0] microstep_code,
  output logic                phase_a1,
  output logic                phase_a2,
  output logic                phase_b1,
  output logic                phase_b2,
  output logic                pwm_a,
  output logic                pwm_b
);

  logic [index_width-1:0] index;
  logic [index_width-1:0] delta;
  logic [pwm_width-1:0]   pwm_count;
  logic [2:0]             sel_a;
  logic [2:0]             sel_b;
  logic [pwm_width-1:0]   mag_a;
  logic [pwm_width-1:0]   mag_b;

  // Quarter sine sampled half a position off the grid,
  // so the table mirrors cleanly and no coil ever sits at zero
  function automatic logic [pwm_width-1:0] quarter_sine(input logic [2:0] sel);
    case (sel)
      3'd0:    quarter_sine = 8'd25;
      3'd1:    quarter_sine = 8'd74;
      3'd2:    quarter_sine = 8'd120;
      3'd3:    quarter_sine = 8'd162;
      3'd4:    quarter_sine = 8'd197;
      3'd5:    quarter_sine = 8'd225;
      3'd6:    quarter_sine = 8'd244;
      default: quarter_sine = 8'd254;
    endcase
  endfunction

  // Full step moves 8 positions, eighth step moves 1
  assign delta = index_width'(1) << (ms_max - microstep_code);

  // Coil B runs a quarter cycle behind coil A
  assign sel_a = index[3] ? ~index[2:0] : index[2:0];
  assign sel_b = index[3] ? index[2:0] : ~index[2:0];
  assign mag_a = quarter_sine(sel_a);
  assign mag_b = quarter_sine(sel_b);

  assign phase_a1 = ~index[4];              // Positions 0 to 15
  assign phase_a2 = index[4];
  assign phase_b1 = index[4] ^ index[3];    // Positions 8 to 23
  assign phase_b2 = ~(index[4] ^ index[3]);

  always_ff @(posedge CLK) begin
    if (reset) begin
      index     <= '0;
      pwm_count <= '0;
      pwm_a     <= 1'b0;
      pwm_b     <= 1'b0;
    end else begin
      pwm_count <= pwm_count + 1'b1;        // Free running, wraps
      pwm_a     <= (pwm_count < mag_a);
      pwm_b     <= (pwm_count < mag_b);
      if (step) begin
        if (dir) index <= index + delta;
        else index <= index - delta;
      end
    end
  end

endmodule

`default_nettype wire

//--- hw/motion_profile.sv
`default_nettype none

module motion_profile import stepper_pkg::*; (
  input  logic                         CLK,
  input  logic                         reset,
  input  logic                         move_start,
  input  logic                         move_dir,
  input  logic [duration_width-1:0]    move_duration,
  input  logic signed [rate_width-1:0] move_rate,
  input  logic signed [rate_width-1:0] move_accel,
  input  logic [divisor_width-1:0]     tick_divisor,
  output logic                         step,
  output logic                         dir,
  output logic                         move_busy
);

  localparam logic [rate_width-1:0] rate_max = {1'b0, {(rate_width-1){1'b1}}};

  logic [divisor_width-1:0]     div_count;
  logic [divisor_width-1:0]     divisor_q;
  logic [duration_width-1:0]    tick_count;
  logic [duration_width-1:0]    duration_q;
  logic signed [rate_width-1:0] rate_q;
  logic signed [rate_width-1:0] accel_q;
  logic [rate_width-1:0]        phase;

  logic                         done;
  logic                         tick;
  logic signed [rate_width:0]   rate_sum;
  logic [rate_width-1:0]        rate_next;
  logic [rate_width:0]          phase_sum;  // MSB is the step carry

  assign done = (tick_count == duration_q);
  assign tick = move_busy && !done && (div_count == divisor_q - 1'b1);

  // Extra bit keeps the sum exact before saturation
  assign rate_sum = rate_q + accel_q;

  always_comb begin
    if (rate_sum[rate_width]) begin
      rate_next = '0;                        // Never run backwards
    end else if (rate_sum[rate_width-1]) begin
      rate_next = rate_max;
    end else begin
      rate_next = rate_sum[rate_width-1:0];
    end
  end

  assign phase_sum = {1'b0, phase} + {1'b0, rate_next};

  always_ff @(posedge CLK) begin
    if (reset) begin
      move_busy  <= 1'b0;
      step       <= 1'b0;
      div_count  <= '0;
      tick_count <= '0;
    end else begin
      step <= 1'b0;
      if (move_start) begin
        move_busy  <= 1'b1;
        div_count  <= '0;
        tick_count <= '0;
      end else if (move_busy) begin
        if (done) begin
          move_busy <= 1'b0;                 // Also covers a zero duration
        end else if (tick) begin
          div_count  <= '0;
          tick_count <= tick_count + 1'b1;
          step       <= phase_sum[rate_width];
        end else begin
          div_count <= div_count + 1'b1;
        end
      end
    end
  end

  // Move parameters and accumulator state
  always_ff @(posedge CLK) begin
    if (move_start) begin
      divisor_q  <= tick_divisor;
      duration_q <= move_duration;
      rate_q     <= move_rate;
      accel_q    <= move_accel;
      phase      <= '0;
      dir        <= move_dir;
    end else if (tick) begin
      rate_q <= rate_next;
      phase  <= phase_sum[rate_width-1:0];
    end
  end

endmodule

`default_nettype wire

//--- hw/spi_word_receiver.sv
`default_nettype none

module spi_word_receiver import stepper_pkg::*; (
  input  logic                  CLK,
  input  logic                  reset,
  input  logic                  sck,
  input  logic                  ssel,
  input  logic                  mosi,
  output logic                  miso,
  output logic [word_width-1:0] word_data,
  output logic                  word_valid
);

  // Wide enough to count past word_width
  localparam int count_width = $clog2(word_width + 2);

  logic [1:0] sck_sync;                  // [0] meta, [1] stable
  logic [1:0] ssel_sync;
  logic [1:0] mosi_sync;
  logic       sck_prev;
  logic       ssel_prev;

  logic sck_rise;
  logic sck_fall;
  logic ssel_rise;
  logic ssel_fall;
  logic active;

  logic [count_width-1:0] bit_count;
  logic [1:0]             done_pipe;     // Delays word_valid to 3 cycles after SSEL rise
  logic                   word_ok;
  logic [word_width-1:0]  rx_shift;
  logic [word_width-1:0]  tx_shift;
  logic [word_width-1:0]  echo_word;

  assign sck_rise  = sck_sync[1] & ~sck_prev;
  assign sck_fall  = ~sck_sync[1] & sck_prev;
  assign ssel_rise = ssel_sync[1] & ~ssel_prev;
  assign ssel_fall = ~ssel_sync[1] & ssel_prev;
  assign active    = ~ssel_sync[1];

  // Exactly one word worth of rising edges
  assign word_ok = ssel_rise && (bit_count == count_width'(word_width));

  assign miso = tx_shift[word_width-1];  // MSB first

  always_ff @(posedge CLK) begin
    if (reset) begin
      sck_sync   <= '0;
      ssel_sync  <= '1;                  // Bus idles deselected
      mosi_sync  <= '0;
      sck_prev   <= 1'b0;
      ssel_prev  <= 1'b1;
      bit_count  <= '0;
      done_pipe  <= '0;
      word_valid <= 1'b0;
      tx_shift   <= '0;
      echo_word  <= '0;
    end else begin
      sck_sync  <= {sck_sync[0], sck};
      ssel_sync <= {ssel_sync[0], ssel};
      mosi_sync <= {mosi_sync[0], mosi};
      sck_prev  <= sck_sync[1];
      ssel_prev <= ssel_sync[1];

      // Count rising edges, stop once the word is known to be too long
      if (ssel_fall) begin
        bit_count <= '0;
      end else if (active && sck_rise && bit_count <= count_width'(word_width)) begin
        bit_count <= bit_count + 1'b1;
      end

      // Mode 0: echo data changes on the falling edge
      if (ssel_fall) begin
        tx_shift <= echo_word;
      end else if (active && sck_fall) begin
        tx_shift <= {tx_shift[word_width-2:0], 1'b0};
      end

      done_pipe  <= {done_pipe[0], word_ok};
      word_valid <= done_pipe[1];
      if (done_pipe[0]) echo_word <= word_data;  // Sent back on the next transfer
    end
  end

  always_ff @(posedge CLK) begin
    if (active && sck_rise) begin
      rx_shift <= {rx_shift[word_width-2:0], mosi_sync[1]};
    end
    if (word_ok) word_data <= rx_shift;
  end

endmodule

`default_nettype wire

//--- hw/stepper_pkg.sv
`default_nettype none

package stepper_pkg;

  // SPI framing
  localparam int word_width = 64;
  localparam int hdr_width = 8;              // Top byte of each word

  // Header codes
  localparam logic [hdr_width-1:0] hdr_move = 8'h01;
  localparam logic [hdr_width-1:0] hdr_divisor = 8'h03;
  localparam logic [hdr_width-1:0] hdr_microstep = 8'h04;

  // Tick divider
  localparam int divisor_width = 24;
  localparam int divisor_reset = 32;         // Divisor until the host sets one

  // Move profile, rate and accel are signed, phase is unsigned
  localparam int rate_width = 32;
  localparam int duration_width = 32;        // Move length in ticks

  // Microstepping
  // Code n selects 2**n microsteps per full step
  localparam int ms_width = 2;
  localparam int ms_max = 3;

  // One electrical cycle is 32 index positions at 8 microsteps
  localparam int index_width = 5;

  // PWM counter and magnitude table entries
  localparam int pwm_width = 8;

endpackage

`default_nettype wire

//--- hw/stepper_top.sv
`default_nettype none

module stepper_top import stepper_pkg::*; #(
  parameter int divisor_init = divisor_reset
) (
  input  logic       CLK,
  input  logic       reset,
  input  logic       sck,
  input  logic       ssel,
  input  logic       mosi,
  output logic       miso,
  output logic       phase_a1,
  output logic       phase_a2,
  output logic       phase_b1,
  output logic       phase_b2,
  output logic       pwm_a,
  output logic       pwm_b,
  output logic       step,
  output logic       move_busy,
  output logic [7:0] dropped_moves
);

  logic [word_width-1:0]        word_data;
  logic                         word_valid;
  logic                         move_start;
  logic                         move_dir;
  logic [duration_width-1:0]    move_duration;
  logic signed [rate_width-1:0] move_rate;
  logic signed [rate_width-1:0] move_accel;
  logic [divisor_width-1:0]     tick_divisor;
  logic [ms_width-1:0]          microstep_code;
  logic                         dir;

  spi_word_receiver u_receiver (
    .CLK        (CLK),
    .reset      (reset),
    .sck        (sck),
    .ssel       (ssel),
    .mosi       (mosi),
    .miso       (miso),
    .word_data  (word_data),
    .word_valid (word_valid)
  );

  command_decoder #(
    .divisor_init (divisor_init)
  ) u_decoder (
    .CLK            (CLK),
    .reset          (reset),
    .word_data      (word_data),
    .word_valid     (word_valid),
    .move_busy      (move_busy),
    .move_start     (move_start),
    .move_dir       (move_dir),
    .move_duration  (move_duration),
    .move_rate      (move_rate),
    .move_accel     (move_accel),
    .tick_divisor   (tick_divisor),
    .microstep_code (microstep_code),
    .dropped_moves  (dropped_moves)
  );

  motion_profile u_profile (
    .CLK           (CLK),
    .reset         (reset),
    .move_start    (move_start),
    .move_dir      (move_dir),
    .move_duration (move_duration),
    .move_rate     (move_rate),
    .move_accel    (move_accel),
    .tick_divisor  (tick_divisor),
    .step          (step),
    .dir           (dir),
    .move_busy     (move_busy)
  );

  dual_hbridge u_bridge (
    .CLK            (CLK),
    .reset          (reset),
    .step           (step),
    .dir            (dir),
    .microstep_code (microstep_code),
    .phase_a1       (phase_a1),
    .phase_a2       (phase_a2),
    .phase_b1       (phase_b1),
    .phase_b2       (phase_b2),
    .pwm_a          (pwm_a),
    .pwm_b          (pwm_b)
  );

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module stepper_tb --Mdir obj_dir
status=0
./obj_dir/Vstepper_tb > sim.log 2>&1 || status=$?
cat sim.log
if grep -q "TEST FAILED" sim.log || [ "$status" -ne 0 ]; then
  echo "Simulation failed"
  exit 1
fi
echo "Simulation passed"

//--- verification/stepper_checker.sv
`default_nettype none

module stepper_checker (
  input logic CLK,
  input logic reset,
  input logic step,
  input logic phase_a1,
  input logic phase_a2,
  input logic phase_b1,
  input logic phase_b2
);

  logic [3:0] coils;

  assign coils = {phase_a1, phase_a2, phase_b1, phase_b2};

  // Each step is a single-cycle pulse from the profile
  step_single: assert property (@(posedge CLK) disable iff (reset) step |=> !step)
    else $error("step stayed high for two consecutive cycles");

  // Coil polarity only moves in the cycle after a step
  coil_after_step: assert property (@(posedge CLK) disable iff (reset)
    (coils != $past(coils)) |-> $past(step))
    else $error("coil polarity changed without a step");

  // At most a full step per pulse, so the two coils never flip together
  coil_one_flip: assert property (@(posedge CLK) disable iff (reset)
    !((phase_a1 != $past(phase_a1)) && (phase_b1 != $past(phase_b1))))
    else $error("both coils changed polarity in the same cycle");

endmodule

`default_nettype wire

//--- verification/stepper_tb.sv
`default_nettype none

module stepper_tb;

  localparam int move_count = 18;
  localparam int move_divisor = 4;
  localparam int transfer_count = 84;
  localparam int transfer_cycles = 540;      // Lead-in, 64 bits of 8 clocks, tail
  localparam int pwm_window = 256;           // One full PWM counter period
  localparam longint rate_top = 64'h7fff_ffff;
  localparam longint phase_span = 64'h1_0000_0000;
  localparam real pi = 3.14159265358979;

  logic       CLK;
  logic       reset;
  logic       sck;
  logic       ssel;
  logic       mosi;
  logic       miso;
  logic       phase_a1;
  logic       phase_a2;
  logic       phase_b1;
  logic       phase_b2;
  logic       pwm_a;
  logic       pwm_b;
  logic       step;
  logic       move_busy;
  logic [7:0] dropped_moves;

  logic [31:0] mv_dur [move_count];
  logic [31:0] mv_rate [move_count];
  logic [31:0] mv_accel [move_count];
  logic        mv_dir [move_count];

  logic [31:0] lcg_state = 32'd8;
  logic [4:0]  exp_index = '0;               // Bridge position predicted from steps
  logic        cur_dir = 1'b0;
  int          cur_code = 0;
  int          step_total = 0;
  int          busy_cycles = 0;
  int          cycle_count = 0;
  int          cycle_limit = 0;
  int          checks = 0;
  int          errors = 0;
  int          test_errors = 0;
  int          test_num = 0;
  string       test_name;
  logic [63:0] rx_word;

  tb_clock u_clock (.CLK(CLK));

  stepper_top #(
    .divisor_init (32)
  ) DUT (
    .CLK (CLK), .reset (reset), .sck (sck), .ssel (ssel), .mosi (mosi), .miso (miso),
    .phase_a1 (phase_a1), .phase_a2 (phase_a2), .phase_b1 (phase_b1), .phase_b2 (phase_b2),
    .pwm_a (pwm_a), .pwm_b (pwm_b), .step (step), .move_busy (move_busy),
    .dropped_moves (dropped_moves)
  );

  bind dual_hbridge stepper_checker u_checker (
    .CLK (CLK), .reset (reset), .step (step), .phase_a1 (phase_a1), .phase_a2 (phase_a2),
    .phase_b1 (phase_b1), .phase_b2 (phase_b2)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic int clamp_code(input int value);
    return (value > 3) ? 3 : value;
  endfunction

  // Steps of one move, counted as carries of the phase accumulator
  function automatic int profile_steps(input logic [31:0] duration, input logic [31:0] rate,
                                       input logic [31:0] accel);
    longint r;
    longint acc;
    longint i;
    int     steps;
    r = longint'($signed(rate));
    acc = 0;
    steps = 0;
    for (i = 0; i < longint'(duration); i++) begin
      r = r + longint'($signed(accel));
      if (r < 0) r = 0;
      else if (r > rate_top) r = rate_top;
      acc = acc + r;
      if (acc >= phase_span) begin
        steps++;
        acc = acc - phase_span;
      end
    end
    return steps;
  endfunction

  // Coil current as the sine of the electrical angle, taken mid-position
  function automatic int coil_magnitude(input logic [4:0] index, input logic coil_b);
    real angle;
    real level;
    angle = (real'(index) + (coil_b ? 8.5 : 0.5)) * pi / 16.0;
    level = $sin(angle);
    if (level < 0.0) level = -level;
    return $rtoi(255.0 * level + 0.5);
  endfunction

  // Tally steps and follow the bridge index
  always @(negedge CLK) begin
    if (!reset) begin
      if (step) begin
        if (cur_dir) exp_index = exp_index + 5'(1 << (3 - cur_code));
        else exp_index = exp_index - 5'(1 << (3 - cur_code));
        step_total++;
      end
      if (move_busy) busy_cycles++;
    end
  end

  always @(posedge CLK) begin
    cycle_count++;
    if (cycle_count > cycle_limit) begin
      $display("timeout after %0d cycles, the run did not complete", cycle_count);
      $display("TEST FAILED");
      $finish;
    end
  end

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      test_errors++;
      $display("error %s: expected 0x%0h, got 0x%0h", name, exp, got);
    end
  endtask

  task automatic check_condition(input logic cond, input string what);
    checks++;
    assert (cond) else begin
      errors++;
      test_errors++;
      $display("%s", what);
    end
  endtask

  task automatic check_coils();
    logic a_exp;
    logic b_exp;
    int   high_a;
    int   high_b;
    int   k;
    a_exp = (exp_index < 5'd16);
    b_exp = (exp_index >= 5'd8) && (exp_index <= 5'd23);
    check_value("phase_a1", phase_a1, a_exp);
    check_value("phase_a2", phase_a2, !a_exp);
    check_value("phase_b1", phase_b1, b_exp);
    check_value("phase_b2", phase_b2, !b_exp);
    high_a = 0;
    high_b = 0;
    for (k = 0; k < pwm_window; k++) begin
      @(negedge CLK);
      if (pwm_a) high_a++;
      if (pwm_b) high_b++;
    end
    check_value("pwm_a", high_a, coil_magnitude(exp_index, 1'b0));  // High cycles per period
    check_value("pwm_b", high_b, coil_magnitude(exp_index, 1'b1));
  endtask

  // Mode 0 host, sends the top nbits of tx MSB first
  task automatic spi_transfer(input logic [63:0] tx, input int nbits,
                              output logic [63:0] rx);
    int i;
    rx = '0;
    ssel = 1'b0;
    repeat (4) @(negedge CLK);
    for (i = 0; i < nbits; i++) begin
      mosi = tx[63 - i];
      repeat (4) @(negedge CLK);
      rx = {rx[62:0], miso};                 // Sampled as SCK rises
      sck = 1'b1;
      repeat (4) @(negedge CLK);
      sck = 1'b0;
    end
    repeat (4) @(negedge CLK);
    ssel = 1'b1;
    mosi = 1'b0;
    repeat (10) @(negedge CLK);              // Word reaches the decoder
  endtask

  task automatic load_move(input logic dir, input logic [31:0] dur, input logic [31:0] rate,
                           input logic [31:0] accel);
    spi_transfer({8'h01, 55'd0, dir}, 64, rx_word);
    spi_transfer({32'd0, dur}, 64, rx_word);
    spi_transfer({32'd0, rate}, 64, rx_word);
    spi_transfer({32'd0, accel}, 64, rx_word);
  endtask

  task automatic set_divisor(input int value);
    spi_transfer({8'h03, 32'd0, 24'(value)}, 64, rx_word);
  endtask

  task automatic set_microstep(input int value);
    spi_transfer({8'h04, 53'd0, 3'(value)}, 64, rx_word);
    cur_code = clamp_code(value);
  endtask

  task automatic run_move(input int idx);
    int base_steps;
    int base_busy;
    base_steps = step_total;
    base_busy = busy_cycles;
    cur_dir = mv_dir[idx];
    load_move(mv_dir[idx], mv_dur[idx], mv_rate[idx], mv_accel[idx]);
    while (move_busy) @(negedge CLK);
    repeat (3) @(negedge CLK);
    check_condition(busy_cycles > base_busy,
                    $sformatf("move %0d never raised move_busy", idx));
    check_value("step_count", step_total - base_steps,
                profile_steps(mv_dur[idx], mv_rate[idx], mv_accel[idx]));
    check_coils();
  endtask

  task automatic store_move(input int idx, input logic dir, input logic [31:0] dur,
                            input logic [31:0] rate, input logic [31:0] accel);
    mv_dir[idx] = dir;
    mv_dur[idx] = dur;
    mv_rate[idx] = rate;
    mv_accel[idx] = accel;
  endtask

  task automatic build_moves();
    int i;
    store_move(0, 1'b1, 40, 32'h2000_0000, 32'h0);
    store_move(1, 1'b0, 100, 32'h0, 32'h0040_0000);
    store_move(2, 1'b1, 0, 32'h7fff_ffff, 32'h0);
    store_move(3, 1'b1, 30, 32'h7000_0000, 32'h2000_0000);  // Saturates high
    store_move(4, 1'b0, 80, 32'h4000_0000, 32'hff00_0000);  // Slows to a stop
    for (i = 5; i < 11; i++) begin
      lcg_state = lcg_next(lcg_state);
      mv_dur[i] = 32'(lcg_state[31:24]);
      lcg_state = lcg_next(lcg_state);
      mv_rate[i] = {2'b00, lcg_state[31:2]};
      lcg_state = lcg_next(lcg_state);
      mv_accel[i] = {{6{lcg_state[31]}}, lcg_state[31:6]};
      mv_dir[i] = lcg_state[30];
    end
    store_move(11, 1'b1, 24, 32'h4000_0000, 32'h0);
    store_move(12, 1'b0, 36, 32'h4000_0000, 32'h0);
    store_move(13, 1'b1, 28, 32'h4000_0000, 32'h0);
    store_move(14, 1'b0, 44, 32'h4000_0000, 32'h0);
    store_move(15, 1'b1, 20, 32'h6000_0000, 32'h0);
    store_move(16, 1'b1, 1200, 32'h1800_0000, 32'h0);       // Outlasts four transfers
    store_move(17, 1'b0, 50, 32'h3000_0000, 32'h0010_0000);
  endtask

  task automatic begin_test(input int num, input string name);
    test_num = num;
    test_name = name;
    test_errors = 0;
  endtask

  task automatic end_test();
    $display("test %0d %s: %s", test_num, test_name, (test_errors == 0) ? "passed" : "failed");
  endtask

  initial begin
    int i;
    int drop_base;
    int step_base;
    reset = 1'b1;
    sck = 1'b0;
    ssel = 1'b1;
    mosi = 1'b0;
    build_moves();
    cycle_limit = transfer_count * transfer_cycles + move_count * pwm_window + 500;
    for (i = 0; i < move_count; i++) cycle_limit += (int'(mv_dur[i]) + 4) * move_divisor;
    repeat (5) @(posedge CLK);
    @(negedge CLK);
    reset = 1'b0;

    begin_test(1, "echo");
    spi_transfer(64'h00c3_5a96_0f1e_2d3c, 64, rx_word);
    check_value("miso_word", rx_word, 64'h0);
    spi_transfer(64'h7e12_3456_789a_bcde, 64, rx_word);
    check_value("miso_word", rx_word, 64'h00c3_5a96_0f1e_2d3c);
    end_test();

    begin_test(2, "move step count");
    set_divisor(move_divisor);
    for (i = 0; i < 11; i++) run_move(i);
    end_test();

    begin_test(3, "direction and microsteps");
    set_microstep(3);
    run_move(11);
    run_move(12);
    set_microstep(0);
    run_move(13);
    run_move(14);
    set_microstep(7);                        // Clamps to eighth steps
    run_move(15);
    end_test();

    begin_test(4, "drop while busy");
    drop_base = dropped_moves;
    step_base = step_total;
    cur_dir = mv_dir[16];
    load_move(mv_dir[16], mv_dur[16], mv_rate[16], mv_accel[16]);
    load_move(1'b0, 100, 32'h7000_0000, 32'h0);
    check_condition(move_busy, "move_busy was low when the second move arrived");
    check_value("dropped_moves", dropped_moves, 8'(drop_base + 1));
    while (move_busy) @(negedge CLK);
    repeat (20) @(negedge CLK);
    check_value("step_count", step_total - step_base,
                profile_steps(mv_dur[16], mv_rate[16], mv_accel[16]));
    check_coils();
    end_test();

    begin_test(5, "ignored input");
    drop_base = dropped_moves;
    spi_transfer({8'hee, 56'h12_3456_789a_bcd0}, 64, rx_word);
    spi_transfer(64'h1000_0000_0000_0010, 60, rx_word);  // Would read as a move header if kept
    run_move(17);
    check_value("dropped_moves", dropped_moves, 8'(drop_base));
    end_test();

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verification/tb_clock.sv
`default_nettype none

module tb_clock (
  output logic CLK
);

  initial begin
    CLK = 1'b0;
    forever #10 CLK = ~CLK;  // Period of 20
  end

endmodule

`default_nettype wire

//--- verilog.f
hw/stepper_pkg.sv
hw/spi_word_receiver.sv
hw/command_decoder.sv
hw/motion_profile.sv
hw/dual_hbridge.sv
hw/stepper_top.sv
verification/tb_clock.sv
verification/stepper_checker.sv
verification/stepper_tb.sv
